// ==== common/pa_pkg.sv ====
// shared types and codes for the p-a unit; words are numbered big-endian with bit 0 as MSB
package pa_pkg;

	typedef logic [0:15] word_t;     // data or address word, bit 0 is the MSB
	typedef logic [2:0]  alu_op_t;   // encoded alu operation
	typedef logic [2:0]  abus_sel_t; // a-bus source select
	typedef logic [2:0]  wbus_sel_t; // w-bus source select

	// alu operation table
	localparam alu_op_t ALU_ADD     = 3'd0; // a + ac + cin
	localparam alu_op_t ALU_SUB     = 3'd1; // a - ac - cin
	localparam alu_op_t ALU_AND     = 3'd2;
	localparam alu_op_t ALU_OR      = 3'd3;
	localparam alu_op_t ALU_XOR     = 3'd4;
	localparam alu_op_t ALU_PASS_A  = 3'd5;
	localparam alu_op_t ALU_PASS_AC = 3'd6;
	localparam alu_op_t ALU_NOT_A   = 3'd7;

	// a-bus sources, unlisted codes give zero
	localparam abus_sel_t A_ZERO = 3'd0;
	localparam abus_sel_t A_L    = 3'd1;
	localparam abus_sel_t A_IR   = 3'd2;
	localparam abus_sel_t A_AR   = 3'd3;
	localparam abus_sel_t A_IC   = 3'd4;

	// w-bus sources
	localparam wbus_sel_t W_ZERO = 3'd0;
	localparam wbus_sel_t W_A    = 3'd1;
	localparam wbus_sel_t W_AC   = 3'd2;
	localparam wbus_sel_t W_AT   = 3'd3;
	localparam wbus_sel_t W_IR   = 3'd4;
	localparam wbus_sel_t W_KL   = 3'd5;
	localparam wbus_sel_t W_RDT  = 3'd6;
	localparam wbus_sel_t W_KI   = 3'd7;

	localparam word_t AR_STEP_BACK = 16'd4; // ar count-down step

endpackage

// ==== alu/alu.sv ====
// combinational 16-bit alu; carry, ovf and s_1 are only meaningful for add and sub, zero otherwise
`timescale 1ns/1ps

module alu import pa_pkg::*; (
	input  word_t   a,
	input  word_t   ac,
	input  alu_op_t op,
	input  logic    cin,
	output word_t   f,
	output logic    carry,
	output logic    ovf,
	output logic    zsum,
	output logic    s_1
);

	logic [16:0] sum;
	logic [16:0] diff;
	logic        arith; // add or sub selected
	logic        cout;

	assign sum = {1'b0, a} + {1'b0, ac} + {16'd0, cin};
	assign diff = {1'b0, a} - {1'b0, ac} - {16'd0, cin};

	always_comb begin
		f = '0;
		arith = 1'b0;
		cout = 1'b0;
		ovf = 1'b0;
		case (op)
			ALU_ADD: begin
				f = sum[15:0];
				arith = 1'b1;
				cout = sum[16];
				ovf = (a[0] == ac[0]) & (sum[15] != a[0]); // like signs, sign flipped
			end
			ALU_SUB: begin
				f = diff[15:0];
				arith = 1'b1;
				cout = diff[16]; // borrow out
				ovf = (a[0] != ac[0]) & (diff[15] != a[0]);
			end
			ALU_AND: begin
				f = a & ac;
			end
			ALU_OR: begin
				f = a | ac;
			end
			ALU_XOR: begin
				f = a ^ ac;
			end
			ALU_PASS_A: begin
				f = a;
			end
			ALU_PASS_AC: begin
				f = ac;
			end
			ALU_NOT_A: begin
				f = ~a;
			end
		endcase
	end

	assign carry = cout;

	// sign of the 17-bit result, from sign-extended operands
	assign s_1 = arith & (a[0] ^ ac[0] ^ cout);

	assign zsum = (f == '0);

endmodule

// ==== source/pa_ctrl.sv ====
// strobe phases to one-cycle enables; enables are registered, so loads land two cycles after a strobe rises
`timescale 1ns/1ps

module pa_ctrl (
	input  logic clk_sys,
	input  logic reset,
	input  logic strob1,
	input  logic strob2,
	input  logic as2,
	input  logic w_ac,
	input  logic w_ar,
	input  logic w_ic,
	input  logic arp1,
	input  logic arm4,
	input  logic icp1,
	input  logic wx,
	input  logic zs,
	output logic ac_en,
	output logic at_ld,
	output logic at_sh,
	output logic ar_ld,
	output logic ar_inc,
	output logic ar_dec,
	output logic ic_ld,
	output logic ic_inc,
	output logic wzi
);

	logic phase_a;   // strob1 outside as2
	logic phase_b;   // strob2 inside as2
	logic phase_c;   // strob1 inside as2
	logic phase_a_q;
	logic phase_b_q;
	logic phase_c_q;
	logic rise_a;
	logic rise_b;
	logic rise_c;
	logic rise_ab;
	logic wzi_en;

	assign phase_a = strob1 & ~as2;
	assign phase_b = strob2 & as2;
	assign phase_c = strob1 & as2;

	assign rise_a = phase_a & ~phase_a_q;
	assign rise_b = phase_b & ~phase_b_q;
	assign rise_c = phase_c & ~phase_c_q;
	assign rise_ab = rise_a | rise_b; // either phase for bus loads

	assign wzi_en = at_ld; // same strob1 edge under as2

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			phase_a_q <= 1'b0;
			phase_b_q <= 1'b0;
			phase_c_q <= 1'b0;
			ac_en <= 1'b0;
			ar_ld <= 1'b0;
			ic_ld <= 1'b0;
			ar_inc <= 1'b0;
			ar_dec <= 1'b0;
			ic_inc <= 1'b0;
			at_ld <= 1'b0;
			at_sh <= 1'b0;
		end else begin
			phase_a_q <= phase_a;
			phase_b_q <= phase_b;
			phase_c_q <= phase_c;
			ac_en <= w_ac & rise_ab;
			ar_ld <= w_ar & rise_ab;
			ic_ld <= w_ic & rise_ab;
			ar_inc <= arp1 & rise_a;
			ar_dec <= arm4 & rise_a;
			ic_inc <= icp1 & rise_a;
			at_ld <= rise_c;
			at_sh <= wx & rise_a;
		end
	end

	// alu zero flag
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wzi <= 1'b0;
		end else if (wzi_en) begin
			wzi <= zs;
		end
	end

endmodule

// ==== source/bus_mux.sv ====
// a-bus and w-bus selectors; unused a-bus codes read as zero, ddt is zero unless w_dt
`timescale 1ns/1ps

module bus_mux import pa_pkg::*; (
	input  abus_sel_t abus,
	input  wbus_sel_t wbus,
	input  logic      w_dt,
	input  word_t     l,
	input  word_t     ir,
	input  word_t     ar,
	input  word_t     ic,
	input  word_t     ac,
	input  word_t     at,
	input  word_t     kl,
	input  word_t     rdt,
	input  word_t     ki,
	output word_t     a,
	output word_t     w,
	output word_t     ddt
);

	// alu operand
	always_comb begin
		case (abus)
			A_L:     a = l;
			A_IR:    a = ir;
			A_AR:    a = ar;
			A_IC:    a = ic;
			default: a = '0; // A_ZERO and spare codes
		endcase
	end

	always_comb begin
		case (wbus)
			W_ZERO:  w = '0;
			W_A:     w = a;
			W_AC:    w = ac;
			W_AT:    w = at;
			W_IR:    w = ir;
			W_KL:    w = kl;
			W_RDT:   w = rdt;
			W_KI:    w = ki;
			default: w = '0;
		endcase
	end

	assign ddt = w_dt ? w : '0; // data out to memory

endmodule

// ==== source/acc_regs.sv ====
// accumulator ac and shift register at; at load wins over shift
`timescale 1ns/1ps

module acc_regs import pa_pkg::*; (
	input  logic  clk_sys,
	input  logic  reset,
	input  logic  ac_en,
	input  logic  at_ld,
	input  logic  at_sh,
	input  logic  eat0,
	input  word_t w,
	input  word_t f,
	output word_t ac,
	output word_t at
);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ac <= '0;
		end else if (ac_en) begin
			ac <= w; // from w bus
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			at <= '0;
		end else if (at_ld) begin
			at <= f; // alu result
		end else if (at_sh) begin
			at <= {eat0, at[0:14]}; // right shift, bit 15 drops out
		end
	end

endmodule

// ==== source/addr_regs.sv ====
// ar and ic counters with address out; off clears ic over everything, load beats count
`timescale 1ns/1ps

module addr_regs import pa_pkg::*; (
	input  logic  clk_sys,
	input  logic  reset,
	input  logic  off,
	input  logic  ar_ld,
	input  logic  ar_inc,
	input  logic  ar_dec,
	input  logic  ic_ld,
	input  logic  ic_inc,
	input  logic  ar_ad,
	input  logic  ic_ad,
	input  logic  barnb,
	input  word_t w,
	input  word_t kl,
	output word_t ar,
	output word_t ic,
	output word_t dad,
	output logic  arz,
	output logic  zga
);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ar <= '0;
		end else if (ar_ld) begin
			ar <= w;
		end else if (ar_inc) begin
			ar <= ar + 16'd1;
		end else if (ar_dec) begin
			ar <= ar - AR_STEP_BACK;
		end
	end

	assign arz = (ar == '0);

	always_ff @(posedge clk_sys) begin
		if (reset || off) begin
			ic <= '0;
		end else if (ic_ld) begin
			ic <= w;
		end else if (ic_inc) begin
			ic <= ic + 16'd1;
		end
	end

	always_comb begin
		case ({ar_ad, ic_ad})
			2'b01:   dad = ic;
			2'b10:   dad = ar;
			2'b11:   dad = ar | ic; // both drivers on the bus
			default: dad = '0;
		endcase
	end

	// key match, bit 0 stands for the block select
	assign zga = (kl == {~barnb, dad[1:15]});

endmodule

// ==== source/pa.sv ====
// p-a unit top; no decoder, memory or interrupts here, all selects and strobes come from outside
`timescale 1ns/1ps

module pa import pa_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      strob1,
	input  logic      strob2,
	input  logic      as2,
	input  logic      w_ac,
	input  logic      w_ar,
	input  logic      w_ic,
	input  logic      arp1,
	input  logic      arm4,
	input  logic      icp1,
	input  logic      wx,
	input  logic      eat0,
	input  logic      off,
	input  logic      w_dt,
	input  logic      ar_ad,
	input  logic      ic_ad,
	input  logic      barnb,
	input  logic      cin,
	input  abus_sel_t abus,
	input  wbus_sel_t wbus,
	input  alu_op_t   op,
	input  word_t     l,
	input  word_t     ir,
	input  word_t     kl,
	input  word_t     rdt,
	input  word_t     ki,
	output word_t     w,
	output word_t     ddt,
	output word_t     dad,
	output word_t     f,
	output logic      carry,
	output logic      ovf,
	output logic      s0,
	output logic      s_1,
	output logic      zs,
	output logic      wzi,
	output logic      arz,
	output logic      at15,
	output logic      zga
);

	word_t a;
	word_t ac;
	word_t at;
	word_t ar;
	word_t ic;
	logic  zsum;
	logic  ac_en;
	logic  at_ld;
	logic  at_sh;
	logic  ar_ld;
	logic  ar_inc;
	logic  ar_dec;
	logic  ic_ld;
	logic  ic_inc;

	assign s0 = f[0];
	assign zs = zsum & ~s_1; // zero only with a non-negative true sign
	assign at15 = at[15];

	pa_ctrl i_ctrl (
		.clk_sys(clk_sys), .reset(reset),
		.strob1(strob1), .strob2(strob2), .as2(as2),
		.w_ac(w_ac), .w_ar(w_ar), .w_ic(w_ic),
		.arp1(arp1), .arm4(arm4), .icp1(icp1), .wx(wx), .zs(zs),
		.ac_en(ac_en), .at_ld(at_ld), .at_sh(at_sh),
		.ar_ld(ar_ld), .ar_inc(ar_inc), .ar_dec(ar_dec),
		.ic_ld(ic_ld), .ic_inc(ic_inc), .wzi(wzi)
	);

	bus_mux i_bus_mux (
		.abus(abus), .wbus(wbus), .w_dt(w_dt),
		.l(l), .ir(ir), .ar(ar), .ic(ic), .ac(ac), .at(at),
		.kl(kl), .rdt(rdt), .ki(ki),
		.a(a), .w(w), .ddt(ddt)
	);

	alu i_alu (
		.a(a), .ac(ac), .op(op), .cin(cin),
		.f(f), .carry(carry), .ovf(ovf), .zsum(zsum), .s_1(s_1)
	);

	acc_regs i_acc_regs (
		.clk_sys(clk_sys), .reset(reset),
		.ac_en(ac_en), .at_ld(at_ld), .at_sh(at_sh), .eat0(eat0),
		.w(w), .f(f), .ac(ac), .at(at)
	);

	addr_regs i_addr_regs (
		.clk_sys(clk_sys), .reset(reset), .off(off),
		.ar_ld(ar_ld), .ar_inc(ar_inc), .ar_dec(ar_dec),
		.ic_ld(ic_ld), .ic_inc(ic_inc),
		.ar_ad(ar_ad), .ic_ad(ic_ad), .barnb(barnb),
		.w(w), .kl(kl),
		.ar(ar), .ic(ic), .dad(dad), .arz(arz), .zga(zga)
	);

endmodule

// ==== testbench/pa_asserts.sv ====
// bound into pa; needs the enable and ar nets inside pa under these names
`timescale 1ns/1ps

module pa_asserts import pa_pkg::*; (
	input logic  clk_sys,
	input logic  reset,
	input logic  ac_en,
	input logic  at_ld,
	input logic  at_sh,
	input logic  ar_ld,
	input logic  ar_inc,
	input logic  ar_dec,
	input logic  ic_ld,
	input logic  ic_inc,
	input word_t ar
);

	logic [7:0] en;

	assign en = {ac_en, at_ld, at_sh, ar_ld, ar_inc, ar_dec, ic_ld, ic_inc};

	one_cycle_en: assert property (@(posedge clk_sys) disable iff (reset)
		(en & $past(en)) == 8'd0)
		else $error("register enable stayed high for more than one cycle");

	quiet_reset: assert property (@(posedge clk_sys) reset |=> en == 8'd0)
		else $error("enable active during reset");

	ar_only_on_enable: assert property (@(posedge clk_sys) disable iff (reset)
		!(ar_ld || ar_inc || ar_dec) |=> $stable(ar))
		else $error("ar changed without load or count enable");

endmodule

// ==== testbench/tb_pa.sv ====
// reads testbench/pa_cases.txt from the project root; strobes settle two cycles after they rise
`timescale 1ns/1ps

module tb_pa import pa_pkg::*; ();

	logic      clk_sys = 1'b0;
	logic      reset;
	logic      strob1;
	logic      strob2;
	logic      as2;
	logic      w_ac;
	logic      w_ar;
	logic      w_ic;
	logic      arp1;
	logic      arm4;
	logic      icp1;
	logic      wx;
	logic      eat0;
	logic      off;
	logic      w_dt;
	logic      ar_ad;
	logic      ic_ad;
	logic      barnb;
	logic      cin;
	abus_sel_t abus;
	wbus_sel_t wbus;
	alu_op_t   op;
	word_t     l;
	word_t     ir;
	word_t     kl;
	word_t     rdt;
	word_t     ki;
	word_t     w;
	word_t     ddt;
	word_t     dad;
	word_t     f;
	logic      carry;
	logic      ovf;
	logic      s0;
	logic      s_1;
	logic      zs;
	logic      wzi;
	logic      arz;
	logic      at15;
	logic      zga;

	string       names[64];
	string       kinds[64];
	logic [15:0] fld[64][6]; // mode x y z exp1 exp2
	int          n_cases = 0;
	int          errors = 0;
	int          n_bad = 0;
	bit          case_bad;
	string       cur;

	pa i_dut (.*);

	bind pa pa_asserts i_asserts (
		.clk_sys(clk_sys), .reset(reset), .ac_en(ac_en), .at_ld(at_ld), .at_sh(at_sh),
		.ar_ld(ar_ld), .ar_inc(ar_inc), .ar_dec(ar_dec), .ic_ld(ic_ld), .ic_inc(ic_inc),
		.ar(ar)
	);

	always #2 clk_sys = ~clk_sys;

	// watchdog
	initial begin
		wait (n_cases != 0);
		repeat (16 + n_cases * 40) @(posedge clk_sys);
		$display("timeout: cases did not finish in the allowed number of cycles");
		$display("=== FAIL ===");
		$finish;
	end

	function automatic logic [19:0] predict_alu(input logic [2:0] o, input logic [15:0] av,
		input logic [15:0] acv, input logic ci);
		logic [16:0] u;
		logic [16:0] e;
		logic [15:0] r;
		logic        c;
		logic        v;
		logic        s;
		r = 16'd0;
		c = 1'b0;
		v = 1'b0;
		s = 1'b0;
		case (o)
			3'd0: begin
				u = {1'b0, av} + {1'b0, acv} + {16'd0, ci};
				e = {av[15], av} + {acv[15], acv} + {16'd0, ci};
			end
			3'd1: begin
				u = {1'b0, av} - {1'b0, acv} - {16'd0, ci};
				e = {av[15], av} - {acv[15], acv} - {16'd0, ci};
			end
			default: begin
				u = 17'd0;
				e = 17'd0;
			end
		endcase
		case (o)
			3'd0, 3'd1: begin
				r = u[15:0];
				c = u[16];
				s = e[16]; // true sign
				v = e[16] ^ e[15];
			end
			3'd2: r = av & acv;
			3'd3: r = av | acv;
			3'd4: r = av ^ acv;
			3'd5: r = av;
			3'd6: r = acv;
			default: r = ~av;
		endcase
		return {r, c, v, s, (r == 16'd0) & ~s};
	endfunction

	task automatic check_val(input string tag, input logic [15:0] exp, input logic [15:0] got);
		assert (got === exp) else begin
			$display("[FAIL] %s %s expected %h actual %h", cur, tag, exp, got);
			errors++;
			case_bad = 1'b1;
		end
	endtask

	// one strobe cycle then the edge detect and load cycles
	task automatic pulse(input logic s1, input logic s2, input logic a2);
		@(posedge clk_sys);
		strob1 <= s1;
		strob2 <= s2;
		as2 <= a2;
		@(posedge clk_sys);
		strob1 <= 1'b0;
		strob2 <= 1'b0;
		as2 <= 1'b0;
		@(posedge clk_sys);
		@(posedge clk_sys);
		w_ac <= 1'b0;
		w_ar <= 1'b0;
		w_ic <= 1'b0;
		arp1 <= 1'b0;
		arm4 <= 1'b0;
		icp1 <= 1'b0;
		wx <= 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic load_ac(input logic [15:0] v);
		@(posedge clk_sys);
		rdt <= v;
		wbus <= W_RDT;
		w_ac <= 1'b1;
		pulse(1'b1, 1'b0, 1'b0);
	endtask

	task automatic preset_addr(input logic [15:0] v, input bit to_ic);
		@(posedge clk_sys);
		l <= v;
		abus <= A_L;
		wbus <= W_A;
		w_ar <= !to_ic;
		w_ic <= to_ic;
		pulse(1'b1, 1'b0, 1'b0);
	endtask

	task automatic alu_ops(input logic [15:0] p[6]);
		logic [19:0] m;
		m = predict_alu(p[0][2:0], p[1], p[2], p[3][0]);
		load_ac(p[2]);
		@(posedge clk_sys);
		abus <= A_L;
		l <= p[1];
		op <= p[0][2:0];
		cin <= p[3][0];
		@(negedge clk_sys);
		check_val("model f", p[4], m[19:4]);
		check_val("model flags", p[5], {12'd0, m[3:0]});
		check_val("f", m[19:4], f);
		check_val("flags", {12'd0, m[3:0]}, {12'd0, carry, ovf, s_1, zs});
		check_val("s0", {15'd0, m[19]}, {15'd0, s0});
	endtask

	task automatic strobe_load(input logic [15:0] p[6]);
		logic [15:0] m;
		m = (p[0] < 2) ? p[1] : p[2];
		check_val("model ac", p[4], m);
		load_ac(p[2]);
		@(posedge clk_sys);
		rdt <= p[1];
		w_ac <= 1'b1;
		op <= ALU_PASS_AC; // ac visible on f
		@(posedge clk_sys);
		strob1 <= (p[0] == 0 || p[0] == 3);
		strob2 <= (p[0] == 1 || p[0] == 2);
		as2 <= (p[0] == 1 || p[0] == 3);
		@(posedge clk_sys);
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_val("ac after edge", m, f);
		@(posedge clk_sys);
		rdt <= ~p[1]; // a second load would show this
		repeat (3) @(posedge clk_sys);
		strob1 <= 1'b0;
		strob2 <= 1'b0;
		as2 <= 1'b0;
		w_ac <= 1'b0;
		@(posedge clk_sys);
		wbus <= W_AC;
		@(negedge clk_sys);
		check_val("ac on w", m, w);
	endtask

	task automatic at_shift(input logic [15:0] p[6]);
		logic [15:0] m;
		m = p[1];
		@(posedge clk_sys);
		l <= p[1];
		abus <= A_L;
		op <= ALU_PASS_A;
		wbus <= W_AT;
		pulse(1'b1, 1'b0, 1'b1);
		check_val("at load", m, w);
		for (int i = 0; i < int'(p[2]); i++) begin
			@(posedge clk_sys);
			eat0 <= p[0][0];
			wx <= 1'b1;
			pulse(1'b1, 1'b0, 1'b0);
			m = {p[0][0], m[15:1]};
			check_val("at step", m, w);
			check_val("at15 step", {15'd0, m[0]}, {15'd0, at15});
		end
		check_val("model at", p[4], m);
		check_val("model at15", p[5], {15'd0, m[0]});
	endtask

	task automatic count_regs(input logic [15:0] p[6]);
		logic [15:0] m;
		bit          is_ic;
		is_ic = (p[0] != 0);
		if (p[0] == 2) begin
			m = p[1];
			@(posedge clk_sys);
			l <= p[1];
			abus <= A_L;
			wbus <= W_A;
			w_ic <= 1'b1;
			icp1 <= 1'b1; // count at the same time
			pulse(1'b1, 1'b0, 1'b0);
		end else begin
			if (p[0] == 1 && p[3] != 0) begin
				m = 16'd0; // off clears ic
			end else begin
				m = p[1] + p[2] - ((p[0] == 0) ? 16'd4 * p[3] : 16'd0);
			end
			preset_addr(p[1], is_ic);
			for (int i = 0; i < int'(p[2]); i++) begin
				@(posedge clk_sys);
				arp1 <= !is_ic;
				icp1 <= is_ic;
				pulse(1'b1, 1'b0, 1'b0);
			end
			if (!is_ic) begin
				for (int i = 0; i < int'(p[3]); i++) begin
					@(posedge clk_sys);
					arm4 <= 1'b1;
					pulse(1'b1, 1'b0, 1'b0);
				end
			end else if (p[3] != 0) begin
				@(posedge clk_sys);
				off <= 1'b1;
				@(posedge clk_sys);
				off <= 1'b0;
			end
		end
		@(posedge clk_sys);
		abus <= is_ic ? A_IC : A_AR;
		wbus <= W_A;
		@(negedge clk_sys);
		check_val("model count", p[4], m);
		check_val("count", m, w);
		if (!is_ic) begin
			check_val("model arz", p[5], {15'd0, m == 16'd0});
			check_val("arz", {15'd0, m == 16'd0}, {15'd0, arz});
		end
	endtask

	task automatic addr_path(input logic [15:0] p[6]);
		logic [15:0] dm;
		logic [15:0] kv;
		logic [15:0] kiv;
		logic        dt;
		logic        zm;
		dm = (p[0][2] ? p[1] : 16'd0) | (p[0][1] ? p[2] : 16'd0);
		kv = {~p[0][0], dm[14:0]} ^ ((p[3] != 0) ? 16'd0 : 16'd1);
		zm = (kv == {~p[0][0], dm[14:0]});
		dt = p[0][0] ^ p[3][0]; // both gate values over the addr cases
		kiv = 16'($urandom);
		preset_addr(p[1], 1'b0);
		preset_addr(p[2], 1'b1);
		@(posedge clk_sys);
		ar_ad <= p[0][2];
		ic_ad <= p[0][1];
		barnb <= p[0][0];
		kl <= kv;
		w_dt <= dt;
		ki <= kiv;
		wbus <= W_KI;
		@(negedge clk_sys);
		check_val("model dad", p[4], dm);
		check_val("model zga", p[5], {15'd0, zm});
		check_val("dad", dm, dad);
		check_val("zga", {15'd0, zm}, {15'd0, zga});
		check_val("ddt", dt ? kiv : 16'd0, ddt);
	endtask

	task automatic wzi_capture(input logic [15:0] p[6]);
		logic [19:0] m;
		logic        exp;
		m = predict_alu(p[0][2:0], p[1], p[2], 1'b0);
		exp = p[3][0] & m[0];
		@(posedge clk_sys);
		l <= 16'd1;
		abus <= A_L;
		op <= ALU_PASS_A;
		pulse(1'b1, 1'b0, 1'b1); // nonzero result clears wzi
		check_val("wzi preset", 16'd0, {15'd0, wzi});
		load_ac(p[2]);
		@(posedge clk_sys);
		l <= p[1];
		op <= p[0][2:0];
		cin <= 1'b0;
		pulse(1'b1, 1'b0, p[3][0]);
		check_val("model wzi", p[4], {15'd0, exp});
		check_val("wzi", {15'd0, exp}, {15'd0, wzi});
	endtask

	initial begin
		int    fd;
		int    cnt;
		string line;
		string nm;
		string kd;
		logic [15:0] v[6];
		void'($urandom(80153));
		reset = 1'b1;
		{strob1, strob2, as2, w_ac, w_ar, w_ic, arp1, arm4, icp1, wx} = '0;
		{eat0, off, w_dt, ar_ad, ic_ad, barnb, cin} = '0;
		abus = A_ZERO;
		wbus = W_ZERO;
		op = ALU_ADD;
		l = '0;
		rdt = '0;
		ir = 16'($urandom);
		kl = 16'($urandom);
		ki = 16'($urandom);
		fd = $fopen("testbench/pa_cases.txt", "r");
		if (fd == 0) begin
			$display("cannot open the case file testbench/pa_cases.txt");
			$display("=== FAIL ===");
			$finish;
		end else begin
			while (!$feof(fd) && n_cases < 64) begin
				line = "";
				cnt = $fgets(line, fd);
				if (cnt > 1 && line[0] != "#") begin
					cnt = $sscanf(line, "%s %s %h %h %h %h %h %h", nm, kd,
						v[0], v[1], v[2], v[3], v[4], v[5]);
					if (cnt == 8) begin
						names[n_cases] = nm;
						kinds[n_cases] = kd;
						fld[n_cases] = v;
						n_cases++;
					end
				end
			end
			$fclose(fd);
			repeat (16) @(posedge clk_sys);
			reset <= 1'b0;
			@(negedge clk_sys);
			for (int i = 0; i < n_cases; i++) begin
				cur = names[i];
				case_bad = 1'b0;
				case (kinds[i])
					"alu":   alu_ops(fld[i]);
					"load":  strobe_load(fld[i]);
					"shift": at_shift(fld[i]);
					"count": count_regs(fld[i]);
					"addr":  addr_path(fld[i]);
					"wzi":   wzi_capture(fld[i]);
					default: begin
						$display("case %s has an unknown kind %s", cur, kinds[i]);
						errors++;
						case_bad = 1'b1;
					end
				endcase
				if (case_bad) begin
					n_bad++;
					$display("%s %s failed", cur, kinds[i]);
				end else begin
					$display("%s %s ok", cur, kinds[i]);
				end
			end
			$display("cases %0d, failed %0d, errors %0d", n_cases, n_bad, errors);
			if (errors == 0 && n_cases > 0) begin
				$display("=== PASS ===");
			end else begin
				$display("=== FAIL ===");
			end
			$finish;
		end
	end

endmodule

// ==== pa.f ====
common/pa_pkg.sv
alu/alu.sv
source/pa_ctrl.sv
source/bus_mux.sv
source/acc_regs.sv
source/addr_regs.sv
source/pa.sv
testbench/pa_asserts.sv
testbench/tb_pa.sv

// ==== Makefile ====
# Verilator build and run of the p-a unit testbench
VERILATOR ?= verilator
TOP       ?= tb_pa
FLIST     ?= pa.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "=== PASS ===" $(LOG); then echo "simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== testbench/pa_cases.txt ====
# columns: name kind mode x y z exp1 exp2, numbers in hex
# alu: mode=op x=a y=ac z=cin exp1=f exp2={carry,ovf,s_1,zs}; other kinds as in tb_pa
add_basic   alu   0 1234 0001 0 1235 0
add_carry   alu   0 ffff 0001 0 0000 9
add_ovf     alu   0 7fff 0001 0 8000 4
add_cin     alu   0 0010 0020 1 0031 0
sub_basic   alu   1 0005 0003 0 0002 0
sub_neg     alu   1 0003 0005 0 fffe a
sub_zero    alu   1 1111 1111 0 0000 1
sub_ovf     alu   1 8000 0001 0 7fff 6
and_op      alu   2 f0f0 ff00 0 f000 0
or_op       alu   3 f0f0 0f00 0 fff0 0
xor_op      alu   4 aaaa aaaa 0 0000 1
pass_a      alu   5 1357 ffff 0 1357 0
pass_ac     alu   6 1357 2468 0 2468 0
not_a       alu   7 00ff 0000 0 ff00 0
ld_s1       load  0 beef 1111 0 beef 0
ld_s2_as2   load  1 cafe 2222 0 cafe 0
ld_s2_noas2 load  2 dead 3333 0 3333 0
ld_s1_as2   load  3 5a5a 4444 0 4444 0
sh_zero     shift 0 8001 1 0 4000 0
sh_one      shift 1 0003 1 0 8001 1
sh_four     shift 1 1234 4 0 f123 1
sh_five     shift 0 ffff 5 0 07ff 1
ar_inc3     count 0 00fe 3 0 0101 0
ar_dec      count 0 0010 0 2 0008 0
ar_zero     count 0 0007 1 2 0000 1
ar_wrap     count 0 0002 0 1 fffe 0
ic_inc2     count 1 0100 2 0 0102 0
ic_off      count 1 abcd 1 1 0000 0
ic_ld_wins  count 2 4321 0 0 4321 0
ad_none     addr  0 1234 5678 1 0000 1
ad_ic       addr  2 1234 0678 1 0678 1
ad_ar       addr  4 1234 5678 0 1234 0
ad_both     addr  6 1200 0034 1 1234 1
ad_barnb    addr  5 9234 0000 1 9234 1
ad_miss     addr  7 0f00 00f0 0 0ff0 0
wz_cap      wzi   1 1111 1111 1 1 0
wz_hold     wzi   1 1111 1111 0 0 0
wz_nz       wzi   0 0001 0001 1 0 0
wz_xor      wzi   4 aaaa aaaa 1 1 0
